/* all.f */
+incdir+source
source/bus_pkg.sv
source/radar_pkg.sv
source/radar_regs.sv
source/radar_timing.sv
source/chirp_gen.sv
source/echo_integrator.sv
source/radar_core.sv
verification/radar_core_tb.sv

/* Makefile */
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP = radar_core_tb
FILELIST = all.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

/* verification/radar_core_tb.sv */
// Radar core testbench
`timescale 1ns/100ps
`default_nettype none

`include "radar_consts.svh"

module radar_core_tb;

   localparam int CLK_HALF   = 2;
   localparam int RST_CYCLES = 5;
   // Cycles per test including register writes
   localparam int T_RESET   = 100 + 10;
   localparam int T_SCHED   = 20 + 3 * 30 + 10;
   localparam int T_CHIRP   = 2 * (20 + 2 * 40);
   localparam int T_ECHO    = 3 * (20 + 3 * 64);
   localparam int T_DISABLE = 20 + 5 + 50 + 2 * 40;
   localparam int WD_CYCLES = RST_CYCLES + T_RESET + T_SCHED + T_CHIRP + T_ECHO
                              + T_DISABLE + 200;

   logic                clk;
   logic                rst_n;
   bus_pkg::ser_bus_t   ser;
   radar_pkg::rx_iq_t   rx;
   logic                rx_strobe;
   radar_pkg::tx_iq_t   tx;
   logic                tx_strobe;
   radar_pkg::echo_iq_t echo;
   logic                echo_strobe;
   logic                io_tx_ena;
   logic                rx_gate;
   logic                tx_side;

   // Expected configuration
   int          m_pulse;
   int          m_guard;
   int          m_rxlen;
   int          m_pri;
   int          m_decim;
   logic [15:0] m_fstart;
   logic [15:0] m_fstep;
   logic        m_side;

   // Reference model state
   logic [15:0] ph;
   logic [15:0] fr;
   int          acc_i;
   int          acc_q;
   int          grp_cnt;
   logic        echo_due;
   int          exp_ei;
   int          exp_eq;
   int          echo_seen;

   logic [15:0] lfsr;
   int          errors;
   int          tests_passed;
   int          tests_failed;

   radar_core i_radar_core (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .ser_i         (ser),
      .rx_i          (rx),
      .rx_strobe_i   (rx_strobe),
      .tx_o          (tx),
      .tx_strobe_o   (tx_strobe),
      .echo_o        (echo),
      .echo_strobe_o (echo_strobe),
      .io_tx_ena_o   (io_tx_ena),
      .rx_gate_o     (rx_gate),
      .tx_side_o     (tx_side)
   );

   always #CLK_HALF clk = ~clk;

   // Galois LFSR stepped once per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         v = {v[14:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   // Triangle from the top 15 phase bits
   function automatic int tri_wave(input logic [15:0] p);
      int u;
      u = int'(p[15:1]);
      if (u < 16384) begin
         return u - 8192;
      end
      return 24575 - u;
   endfunction

   task automatic check_val(input string name, input int got, input int want);
      assert (got == want) else begin
         $display("MISMATCH %s at %0t: got %h, expected %h", name, $time, got, want);
         errors++;
      end
   endtask

   task automatic write_reg(input bus_pkg::reg_addr_e addr, input logic [31:0] data);
      @(negedge clk);
      ser.strobe = 1'b1;
      ser.addr   = addr;
      ser.data   = data;
      @(negedge clk);
      ser.strobe = 1'b0;
   endtask

   // Timing and chirp registers written while disabled
   task automatic configure(input int pulse, input int guard, input int rxl, input int pri,
                            input logic [15:0] fs, input logic [15:0] fstep, input int dec);
      write_reg(bus_pkg::REG_PULSE_LEN, pulse);
      write_reg(bus_pkg::REG_GUARD_LEN, guard);
      write_reg(bus_pkg::REG_RX_LEN, rxl);
      write_reg(bus_pkg::REG_PRI, pri);
      write_reg(bus_pkg::REG_FREQ_START, {16'h0, fs});
      write_reg(bus_pkg::REG_FREQ_STEP, {16'h0, fstep});
      write_reg(bus_pkg::REG_DECIM, dec);
      m_pulse  = pulse;
      m_guard  = guard;
      m_rxlen  = rxl;
      m_pri    = pri;
      m_fstart = fs;
      m_fstep  = fstep;
      m_decim  = dec;
   endtask

   task automatic set_ctrl(input logic side, input logic ena);
      write_reg(bus_pkg::REG_CTRL, {30'h0, side, ena});
      m_side = side;
   endtask

   // Nothing may strobe or gate while idle
   task automatic check_idle(input int ncycles);
      for (int c = 0; c < ncycles; c++) begin
         @(negedge clk);
         check_val("tx_strobe_o", int'(tx_strobe), 0);
         check_val("echo_strobe_o", int'(echo_strobe), 0);
         check_val("io_tx_ena_o", int'(io_tx_ena), 0);
         check_val("rx_gate_o", int'(rx_gate), 0);
         check_val("tx_side_o", int'(tx_side), int'(m_side));
      end
   endtask

   // Follows the schedule from the first transmit cycle after enable
   task automatic watch(input int ncycles, input logic chirp_on, input logic rx_on);
      int          pos;
      int          rx_start;
      logic        exp_tx;
      logic        exp_rx;
      logic        take;
      logic [15:0] r;
      rx_start = m_pulse + m_guard;
      echo_due = 1'b0;
      for (int c = 0; c < ncycles; c++) begin
         @(negedge clk);
         pos    = c % m_pri;
         exp_tx = (pos < m_pulse);
         exp_rx = (pos >= rx_start) && (pos < rx_start + m_rxlen);
         check_val("io_tx_ena_o", int'(io_tx_ena), int'(exp_tx));
         check_val("tx_strobe_o", int'(tx_strobe), int'(exp_tx));
         check_val("rx_gate_o", int'(rx_gate), int'(exp_rx));
         check_val("tx_side_o", int'(tx_side), int'(m_side));
         // Chirp restarts at each pulse
         if (pos == 0) begin
            ph = '0;
            fr = m_fstart;
         end
         if (exp_tx) begin
            if (chirp_on) begin
               check_val("tx_o.i", int'(tx.i), tri_wave(ph));
               check_val("tx_o.q", int'(tx.q), tri_wave(ph + 16'h4000));
            end
            ph = ph + fr;
            fr = fr + m_fstep;
         end
         // Group completed in the previous cycle
         check_val("echo_strobe_o", int'(echo_strobe), int'(echo_due));
         // Groups actually delivered by the core
         if (echo_strobe) begin
            echo_seen++;
         end
         if (echo_due) begin
            check_val("echo_o.i", int'(echo.i), exp_ei);
            check_val("echo_o.q", int'(echo.q), exp_eq);
         end
         echo_due = 1'b0;
         if (pos == rx_start) begin
            acc_i   = 0;
            acc_q   = 0;
            grp_cnt = 0;
         end
         r    = rand_bits(1);
         // Strobe ends with the run
         take = rx_on && r[0] && (c != ncycles - 1);
         rx_strobe = take;
         if (take) begin
            rx.i = rand_bits(16);
            rx.q = rand_bits(16);
            if (exp_rx) begin
               acc_i += int'(rx.i);
               acc_q += int'(rx.q);
               grp_cnt++;
               if (grp_cnt == m_decim) begin
                  exp_ei   = acc_i;
                  exp_eq   = acc_q;
                  echo_due = 1'b1;
                  acc_i    = 0;
                  acc_q    = 0;
                  grp_cnt  = 0;
               end
            end
         end
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: FAILED with %0d errors", name, errors);
      end
      errors = 0;
   endtask

   task automatic test_reset_state();
      m_side = 1'b0;
      check_idle(100);
      finish_test("reset_state");
   endtask

   task automatic test_pulse_schedule();
      configure(6, 3, 10, 30, 16'd256, 16'd64, 4);
      set_ctrl(1'b1, 1'b1);
      watch(3 * 30, 1'b0, 1'b0);
      set_ctrl(1'b0, 1'b0);
      check_idle(2);
      // Side select alone with the transmitter off
      set_ctrl(1'b1, 1'b0);
      check_idle(3);
      set_ctrl(1'b0, 1'b0);
      finish_test("pulse_schedule");
   endtask

   task automatic test_chirp_samples();
      configure(20, 2, 8, 40, 16'd1000, 16'd300, 4);
      set_ctrl(1'b0, 1'b1);
      watch(2 * 40, 1'b1, 1'b0);
      set_ctrl(1'b0, 1'b0);
      // Falling frequency through wraparound
      configure(20, 2, 8, 40, 16'd40000, 16'd65000, 4);
      set_ctrl(1'b0, 1'b1);
      watch(2 * 40, 1'b1, 1'b0);
      set_ctrl(1'b0, 1'b0);
      finish_test("chirp_samples");
   endtask

   task automatic run_echo(input int dec);
      echo_seen = 0;
      configure(6, 3, 48, 64, 16'd256, 16'd64, dec);
      set_ctrl(1'b0, 1'b1);
      watch(3 * 64, 1'b0, 1'b1);
      set_ctrl(1'b0, 1'b0);
      assert (echo_seen > 0) else begin
         $display("no echo groups were produced with decim %0d", dec);
         errors++;
      end
   endtask

   task automatic test_echo_integration();
      run_echo(4);
      run_echo(1);
      run_echo(16);
      finish_test("echo_integration");
   endtask

   task automatic test_disable();
      configure(8, 2, 8, 40, 16'd500, 16'd120, 4);
      set_ctrl(1'b0, 1'b1);
      watch(3, 1'b1, 1'b0);
      // Cleared in the middle of the burst
      set_ctrl(1'b0, 1'b0);
      check_idle(50);
      set_ctrl(1'b0, 1'b1);
      watch(2 * 40, 1'b1, 1'b0);
      set_ctrl(1'b0, 1'b0);
      finish_test("disable");
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      ser          = '0;
      rx           = '0;
      rx_strobe    = 1'b0;
      lfsr         = 16'd43;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      echo_seen    = 0;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      test_reset_state();
      test_pulse_schedule();
      test_chirp_samples();
      test_echo_integration();
      test_disable();
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Ends a run that stops making progress
   initial begin
      #(WD_CYCLES * 2 * CLK_HALF);
      $display("watchdog expired after %0d cycles, tests did not finish", WD_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* source/radar_core.sv */
// Monostatic radar signal core
`timescale 1ns/100ps
`default_nettype none

module radar_core (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   // Register writes from the host
   input  bus_pkg::ser_bus_t   ser_i,
   // ADC samples, one strobe per sample
   input  radar_pkg::rx_iq_t   rx_i,
   input  wire                 rx_strobe_i,
   // DAC samples
   output radar_pkg::tx_iq_t   tx_o,
   output logic                tx_strobe_o,
   // Integrated echoes
   output radar_pkg::echo_iq_t echo_o,
   output logic                echo_strobe_o,
   // Front end controls
   output logic                io_tx_ena_o,
   output logic                rx_gate_o,
   output logic                tx_side_o
);

   radar_pkg::radar_cfg_t cfg;
   logic                  pulse_start;
   logic                  tx_active;
   logic                  rx_window;

   radar_regs i_radar_regs (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .ser_i   (ser_i),
      .cfg_o   (cfg)
   );

   radar_timing i_radar_timing (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg),
      .pulse_start_o (pulse_start),
      .tx_active_o   (tx_active),
      .rx_window_o   (rx_window)
   );

   chirp_gen i_chirp_gen (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg),
      .pulse_start_i (pulse_start),
      .tx_active_i   (tx_active),
      .tx_o          (tx_o),
      .tx_strobe_o   (tx_strobe_o)
   );

   echo_integrator i_echo_integrator (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg),
      .rx_window_i   (rx_window),
      .rx_i          (rx_i),
      .rx_strobe_i   (rx_strobe_i),
      .echo_o        (echo_o),
      .echo_strobe_o (echo_strobe_o)
   );

   // Mixer enable follows the transmit phase, receive gate the receive phase
   assign io_tx_ena_o = tx_active;
   assign rx_gate_o   = rx_window;
   // Side select only, DAC routing is outside the core
   assign tx_side_o   = cfg.tx_side;

endmodule

`default_nettype wire

/* source/echo_integrator.sv */
// Echo group integrator
`timescale 1ns/100ps
`default_nettype none

`include "radar_consts.svh"

module echo_integrator (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  radar_pkg::radar_cfg_t cfg_i,
   // Receive gate from the timing controller
   input  wire                   rx_window_i,
   input  radar_pkg::rx_iq_t     rx_i,
   input  wire                   rx_strobe_i,
   // Group sum, valid with echo_strobe_o
   output radar_pkg::echo_iq_t   echo_o,
   output logic                  echo_strobe_o
);

   localparam int EXT_W = `RADAR_ECHO_W - `RADAR_RX_W;

   logic                            rx_window_q;
   logic [`RADAR_DECIM_W-1:0]       cnt_q;
   logic                            echo_strobe_q;
   logic signed [`RADAR_ECHO_W-1:0] acc_i_q;
   logic signed [`RADAR_ECHO_W-1:0] acc_q_q;
   radar_pkg::echo_iq_t             echo_q;

   logic                            win_start;
   logic                            accept;
   logic                            group_done;
   logic [`RADAR_DECIM_W-1:0]       cnt_next;
   logic signed [`RADAR_ECHO_W-1:0] sum_i;
   logic signed [`RADAR_ECHO_W-1:0] sum_q;

   // Rising edge of the receive gate
   assign win_start = rx_window_i && !rx_window_q;
   // Samples outside the window are dropped
   assign accept    = rx_window_i && rx_strobe_i;

   // A window start discards whatever a previous window left behind
   assign cnt_next = (win_start ? '0 : cnt_q) + 1'b1;
   assign sum_i    = (win_start ? '0 : acc_i_q) + {{EXT_W{rx_i.i[`RADAR_RX_W-1]}}, rx_i.i};
   assign sum_q    = (win_start ? '0 : acc_q_q) + {{EXT_W{rx_i.q[`RADAR_RX_W-1]}}, rx_i.q};

   assign group_done = accept && (cnt_next == cfg_i.decim);

   // Control state
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rx_window_q   <= 1'b0;
         cnt_q         <= '0;
         echo_strobe_q <= 1'b0;
      end else begin
         rx_window_q   <= rx_window_i;
         echo_strobe_q <= group_done;
         if (group_done) begin
            cnt_q <= '0;
         end else if (accept) begin
            cnt_q <= cnt_next;
         end else if (win_start) begin
            cnt_q <= '0;
         end
      end
   end

   // Sums and the emitted group
   always_ff @(posedge clk_i) begin
      if (group_done) begin
         echo_q.i <= sum_i;
         echo_q.q <= sum_q;
         // Next group starts from zero
         acc_i_q  <= '0;
         acc_q_q  <= '0;
      end else if (accept) begin
         acc_i_q <= sum_i;
         acc_q_q <= sum_q;
      end else if (win_start) begin
         acc_i_q <= '0;
         acc_q_q <= '0;
      end
   end

   assign echo_o        = echo_q;
   assign echo_strobe_o = echo_strobe_q;

endmodule

`default_nettype wire

/* source/chirp_gen.sv */
// Linear FM chirp generator
`timescale 1ns/100ps
`default_nettype none

`include "radar_consts.svh"

module chirp_gen (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  radar_pkg::radar_cfg_t cfg_i,
   input  wire                   pulse_start_i,
   input  wire                   tx_active_i,
   // I/Q sample valid with tx_strobe_o
   output radar_pkg::tx_iq_t     tx_o,
   output logic                  tx_strobe_o
);

   // Triangle approximation of a sine over one phase turn
   function automatic logic [`RADAR_TX_W-1:0] triangle(
      input logic [`RADAR_PHASE_W-1:0] p
   );
      logic [`RADAR_PHASE_W-1:0] u;
      logic [`RADAR_PHASE_W-1:0] t;
      // Top 15 bits of the phase
      u = {1'b0, p[`RADAR_PHASE_W-1:1]};
      if (!u[`RADAR_PHASE_W-2]) begin
         // Rising half, -8192 up to 8191
         t = u - `RADAR_PHASE_W'(8192);
      end else begin
         // Falling half, 8191 down to -8192
         t = `RADAR_PHASE_W'(24575) - u;
      end
      return t[`RADAR_TX_W-1:0];
   endfunction

   logic [`RADAR_PHASE_W-1:0] phase_q;
   logic [`RADAR_PHASE_W-1:0] freq_q;

   // Values used this cycle, pulse start forces the initial ones
   logic [`RADAR_PHASE_W-1:0] phase_cur;
   logic [`RADAR_PHASE_W-1:0] freq_cur;

   assign phase_cur = pulse_start_i ? '0 : phase_q;
   assign freq_cur  = pulse_start_i ? cfg_i.freq_start : freq_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q <= '0;
         freq_q  <= '0;
      end else if (tx_active_i) begin
         // Phase steps by the current frequency, then the frequency ramps
         phase_q <= phase_cur + freq_cur;
         freq_q  <= freq_cur + cfg_i.freq_step;
      end
   end

   // Q leads I by a quarter turn
   assign tx_o.i = triangle(phase_cur);
   assign tx_o.q = triangle(phase_cur + `RADAR_QUARTER_TURN);

   // One sample per transmit cycle
   assign tx_strobe_o = tx_active_i;

endmodule

`default_nettype wire

/* source/radar_timing.sv */
// Pulse repetition timing controller
`timescale 1ns/100ps
`default_nettype none

`include "radar_consts.svh"

module radar_timing (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  radar_pkg::radar_cfg_t cfg_i,
   // Strobe in the first transmit cycle
   output logic                  pulse_start_o,
   // High for the whole transmit phase
   output logic                  tx_active_o,
   // High for the whole receive phase
   output logic                  rx_window_o
);

   radar_pkg::radar_state_e state_q;

   // Cycles spent in the current phase
   logic [`RADAR_CNT_W-1:0] phase_cnt_q;
   // Cycles since the last pulse start
   logic [`RADAR_CNT_W-1:0] int_cnt_q;

   logic [`RADAR_CNT_W-1:0] phase_len;
   logic                    phase_done;
   logic                    int_done;

   // Length of the phase being timed
   always_comb begin
      case (state_q)
         radar_pkg::TRANSMIT: phase_len = cfg_i.pulse_len;
         radar_pkg::GUARD:    phase_len = cfg_i.guard_len;
         radar_pkg::RECEIVE:  phase_len = cfg_i.rx_len;
         // Rest ends on the interval counter instead
         default:             phase_len = cfg_i.pri;
      endcase
   end

   assign phase_done = (phase_cnt_q == phase_len - 1'b1);
   // Last cycle of the repetition interval
   assign int_done   = (int_cnt_q == cfg_i.pri - 1'b1);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= radar_pkg::IDLE;
         phase_cnt_q <= '0;
         int_cnt_q   <= '0;
      end else if (!cfg_i.enable) begin
         // Disable wins over every state
         state_q     <= radar_pkg::IDLE;
         phase_cnt_q <= '0;
         int_cnt_q   <= '0;
      end else if (state_q == radar_pkg::IDLE || int_done) begin
         // New pulse, either first after enable or pri after the last
         state_q     <= radar_pkg::TRANSMIT;
         phase_cnt_q <= '0;
         int_cnt_q   <= '0;
      end else begin
         int_cnt_q <= int_cnt_q + 1'b1;
         if (phase_done && state_q != radar_pkg::REST) begin
            phase_cnt_q <= '0;
            case (state_q)
               radar_pkg::TRANSMIT: state_q <= radar_pkg::GUARD;
               radar_pkg::GUARD:    state_q <= radar_pkg::RECEIVE;
               default:             state_q <= radar_pkg::REST;
            endcase
         end else begin
            // Keeps counting in rest, where it is not looked at
            phase_cnt_q <= phase_cnt_q + 1'b1;
         end
      end
   end

   // Decoded straight from the state register
   assign tx_active_o   = (state_q == radar_pkg::TRANSMIT);
   assign rx_window_o   = (state_q == radar_pkg::RECEIVE);
   assign pulse_start_o = tx_active_o && (phase_cnt_q == '0);

endmodule

`default_nettype wire

/* source/radar_regs.sv */
// Radar register decoder
`timescale 1ns/100ps
`default_nettype none

`include "radar_consts.svh"

module radar_regs (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   // Register writes from the serial bus
   input  bus_pkg::ser_bus_t   ser_i,
   // Decoded configuration for the whole core
   output radar_pkg::radar_cfg_t cfg_o
);

   radar_pkg::radar_cfg_t cfg_q;

   // Address of the current write, seen through the register map
   bus_pkg::reg_addr_e addr;

   assign addr = bus_pkg::reg_addr_e'(ser_i.addr);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         // Transmitter held off until software enables it
         cfg_q.enable     <= 1'b0;
         cfg_q.tx_side    <= 1'b0;
         cfg_q.pulse_len  <= `RADAR_RST_PULSE_LEN;
         cfg_q.guard_len  <= `RADAR_RST_GUARD_LEN;
         cfg_q.rx_len     <= `RADAR_RST_RX_LEN;
         cfg_q.pri        <= `RADAR_RST_PRI;
         cfg_q.freq_start <= `RADAR_RST_FREQ_START;
         cfg_q.freq_step  <= `RADAR_RST_FREQ_STEP;
         cfg_q.decim      <= `RADAR_RST_DECIM;
      end else if (ser_i.strobe) begin
         // One field group per address
         case (addr)
            bus_pkg::REG_CTRL: begin
               cfg_q.enable  <= ser_i.data[0];
               cfg_q.tx_side <= ser_i.data[1];
            end
            bus_pkg::REG_PULSE_LEN: begin
               cfg_q.pulse_len <= ser_i.data[`RADAR_CNT_W-1:0];
            end
            bus_pkg::REG_GUARD_LEN: begin
               cfg_q.guard_len <= ser_i.data[`RADAR_CNT_W-1:0];
            end
            bus_pkg::REG_RX_LEN: begin
               cfg_q.rx_len <= ser_i.data[`RADAR_CNT_W-1:0];
            end
            bus_pkg::REG_PRI: begin
               cfg_q.pri <= ser_i.data[`RADAR_CNT_W-1:0];
            end
            bus_pkg::REG_FREQ_START: begin
               cfg_q.freq_start <= ser_i.data[`RADAR_PHASE_W-1:0];
            end
            bus_pkg::REG_FREQ_STEP: begin
               cfg_q.freq_step <= ser_i.data[`RADAR_PHASE_W-1:0];
            end
            bus_pkg::REG_DECIM: begin
               cfg_q.decim <= ser_i.data[`RADAR_DECIM_W-1:0];
            end
            default: begin
               // Other addresses belong to other blocks
               cfg_q <= cfg_q;
            end
         endcase
      end
   end

   assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* source/radar_pkg.sv */
// Radar configuration and sample types
`default_nettype none

`include "radar_consts.svh"

package radar_pkg;

   // Phases of one pulse repetition interval
   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      TRANSMIT = 3'd1,
      GUARD    = 3'd2,
      RECEIVE  = 3'd3,
      REST     = 3'd4
   } radar_state_e;

   // Configuration as decoded from the register bus
   typedef struct packed {
      logic                      enable;
      logic                      tx_side;
      // Phase lengths in clock cycles
      logic [`RADAR_CNT_W-1:0]   pulse_len;
      logic [`RADAR_CNT_W-1:0]   guard_len;
      logic [`RADAR_CNT_W-1:0]   rx_len;
      logic [`RADAR_CNT_W-1:0]   pri;
      // Chirp start frequency and per-sample increment
      logic [`RADAR_PHASE_W-1:0] freq_start;
      logic [`RADAR_PHASE_W-1:0] freq_step;
      logic [`RADAR_DECIM_W-1:0] decim;
   } radar_cfg_t;

   // Transmit I/Q pair for the DAC
   typedef struct packed {
      logic signed [`RADAR_TX_W-1:0] i;
      logic signed [`RADAR_TX_W-1:0] q;
   } tx_iq_t;

   // Received I/Q pair from the ADC side
   typedef struct packed {
      logic signed [`RADAR_RX_W-1:0] i;
      logic signed [`RADAR_RX_W-1:0] q;
   } rx_iq_t;

   // Integrated echo group sums
   typedef struct packed {
      logic signed [`RADAR_ECHO_W-1:0] i;
      logic signed [`RADAR_ECHO_W-1:0] q;
   } echo_iq_t;

endpackage

`default_nettype wire

/* source/bus_pkg.sv */
// Serial register bus types
`default_nettype none

`include "radar_consts.svh"

package bus_pkg;

   // One register write, valid while strobe is high
   typedef struct packed {
      logic                     strobe;
      logic [`RADAR_ADDR_W-1:0] addr;
      logic [`RADAR_DATA_W-1:0] data;
   } ser_bus_t;

   // Register map of the radar application
   typedef enum logic [`RADAR_ADDR_W-1:0] {
      REG_CTRL       = 7'd0,  // bit 0 enable, bit 1 tx side
      REG_PULSE_LEN  = 7'd1,
      REG_GUARD_LEN  = 7'd2,
      REG_RX_LEN     = 7'd3,
      REG_PRI        = 7'd4,
      REG_FREQ_START = 7'd5,
      REG_FREQ_STEP  = 7'd6,
      REG_DECIM      = 7'd7   // 1 to 16 samples per group
   } reg_addr_e;

endpackage

`default_nettype wire

/* source/radar_consts.svh */
// Radar core constants
`ifndef RADAR_CONSTS_SVH
`define RADAR_CONSTS_SVH

// Serial register bus
`define RADAR_ADDR_W 7
`define RADAR_DATA_W 32

// Sample widths
`define RADAR_TX_W 14
`define RADAR_RX_W 16
// Holds a full group of 16 received samples
`define RADAR_ECHO_W 20

// Accumulators and counters
`define RADAR_PHASE_W 16
`define RADAR_CNT_W 16
`define RADAR_DECIM_W 5
// Quarter turn of the phase circle, gives Q from I
`define RADAR_QUARTER_TURN 16'h4000

// Register reset values
`define RADAR_RST_PULSE_LEN 16'd8
`define RADAR_RST_GUARD_LEN 16'd4
`define RADAR_RST_RX_LEN 16'd32
`define RADAR_RST_PRI 16'd64
`define RADAR_RST_FREQ_START 16'd256
`define RADAR_RST_FREQ_STEP 16'd64
`define RADAR_RST_DECIM 5'd4

`endif
